/* compile.f */
+incdir+.
csr_pkg.sv
csr_counter.sv
trap_ctrl.sv
csr_regfile.sv
csr_unit.sv
csr_unit_properties.sv
tb_csr_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CSR unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f compile.f --top-module tb_csr_unit

sim_out=$(./obj_dir/Vtb_csr_unit 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Test passed"; then
  exit 0
else
  exit 1
fi

/* tb_csr_unit.sv */
// Testbench for the CSR unit with a cycle-level reference model, compare process and timeout
`timescale 1ns/10ps
`include "csr_defines.svh"

module tb_csr_unit
  import csr_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 2000;  // About twice the total stimulus length
  localparam int SOFT_ROUNDS    = 40;

  logic      clk;
  logic      rst;
  logic      csr_rd_en;
  csr_addr_t csr_rd_addr;
  xlen_t     csr_rd_data;
  logic      csr_rd_illegal;
  logic      csr_wr_en;
  csr_addr_t csr_wr_addr;
  xlen_t     csr_wr_data;
  logic      excp_req;
  exc_code_t excp_code;
  xlen_t     excp_pc;
  xlen_t     excp_tval;
  logic      mret_req;
  logic      retire;
  logic      redirect_valid;
  xlen_t     redirect_pc;
  logic      trap_active;
  logic      halted;

  // Reference model with one entry per mapped CSR
  xlen_t       model_reg [csr_addr_t];
  trap_state_t model_state;
  logic        model_redir_valid;
  xlen_t       model_redir_pc;
  string       test_name = "reset";
  int          cycle_count = 0;

  csr_addr_t writable_addrs [10] = '{`CSR_MSTATUS, `CSR_MIE, `CSR_MTVEC, `CSR_MSCRATCH,
    `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL, `CSR_MIP, `CSR_MCYCLE, `CSR_MINSTRET};
  csr_addr_t read_only_addrs [5] = '{`CSR_MISA, `CSR_MVENDORID, `CSR_MARCHID,
    `CSR_MIMPID, `CSR_MHARTID};

  csr_unit i_dut (.*);

  always #4 clk = ~clk;

  function automatic xlen_t rand64();
    return {$urandom, $urandom};
  endfunction

  // Expected read data and a known flag that is low for an unmapped address
  function automatic xlen_t csr_expect(input csr_addr_t addr, output logic known);
    xlen_t value;
    value = '0;
    known = 1'b0;
    if (model_reg.exists(addr)) begin
      value = model_reg[addr];
      known = 1'b1;
    end
    return value;
  endfunction

  function automatic logic is_writable(input csr_addr_t addr);
    logic hit;
    hit = 1'b0;
    foreach (writable_addrs[i])
      if (writable_addrs[i] == addr) hit = 1'b1;
    return hit;
  endfunction

  task automatic reset_model();
    foreach (writable_addrs[i])
      model_reg[writable_addrs[i]] = '0;
    foreach (read_only_addrs[i])
      model_reg[read_only_addrs[i]] = '0;  // ID registers are zero
    model_reg[`CSR_MSTATUS] = `MSTATUS_RESET;
    model_reg[`CSR_MISA]    = `MISA_VALUE;
    model_state       = RUN;
    model_redir_valid = 1'b0;
  endtask

  // Applies the inputs seen at this rising edge to the model
  task automatic model_step();
    xlen_t old_status;
    xlen_t old_mtvec;
    xlen_t old_mepc;
    xlen_t new_status;
    logic  enter;
    logic  leave;
    logic  double_trap;
    old_status  = model_reg[`CSR_MSTATUS];
    old_mtvec   = model_reg[`CSR_MTVEC];
    old_mepc    = model_reg[`CSR_MEPC];
    new_status  = old_status;
    enter       = excp_req && (model_state == RUN);
    double_trap = excp_req && (model_state == HANDLER);
    leave       = mret_req && !excp_req && (model_state == HANDLER);
    model_reg[`CSR_MCYCLE] = model_reg[`CSR_MCYCLE] + 64'd1;
    if (retire)
      model_reg[`CSR_MINSTRET] = model_reg[`CSR_MINSTRET] + 64'd1;
    if (csr_wr_en && is_writable(csr_wr_addr))
      model_reg[csr_wr_addr] = csr_wr_data;  // Software write overrides counting
    if (enter) begin
      new_status[`MSTATUS_MPIE_BIT] = old_status[`MSTATUS_MIE_BIT];
      new_status[`MSTATUS_MIE_BIT]  = 1'b0;
      model_reg[`CSR_MSTATUS] = new_status;
      model_reg[`CSR_MEPC]    = {excp_pc[`XLEN-1:1], 1'b0};
      model_reg[`CSR_MCAUSE]  = xlen_t'(excp_code);
      model_reg[`CSR_MTVAL]   = excp_tval;
      model_redir_pc          = {old_mtvec[`XLEN-1:2], 2'b00};
      model_state             = HANDLER;
    end else if (leave) begin
      new_status[`MSTATUS_MIE_BIT]  = old_status[`MSTATUS_MPIE_BIT];
      new_status[`MSTATUS_MPIE_BIT] = 1'b1;
      model_reg[`CSR_MSTATUS] = new_status;
      model_redir_pc          = old_mepc;
      model_state             = RUN;
    end else if (double_trap) begin
      model_state = HALTED;
    end
    model_redir_valid = enter || leave;
  endtask

  task automatic fail_check(input string what, input xlen_t expected, input xlen_t actual);
    $display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
    $display("Test failed");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  // Compare with pre-edge outputs and then advance the model
  always @(posedge clk) begin : compare
    xlen_t exp_data;
    logic  known;
    logic  exp_illegal;
    if (!rst) begin
      exp_data    = csr_expect(csr_rd_addr, known);
      exp_illegal = csr_rd_en && !known;
      if (!csr_rd_en)
        exp_data = '0;
      assert (csr_rd_data === exp_data)
        else fail_check("csr_rd_data", exp_data, csr_rd_data);
      assert (csr_rd_illegal === exp_illegal)
        else fail_check("csr_rd_illegal", xlen_t'(exp_illegal), xlen_t'(csr_rd_illegal));
      assert (redirect_valid === model_redir_valid)
        else fail_check("redirect_valid", xlen_t'(model_redir_valid), xlen_t'(redirect_valid));
      if (model_redir_valid) begin
        assert (redirect_pc === model_redir_pc)
          else fail_check("redirect_pc", model_redir_pc, redirect_pc);
      end
      assert (halted === (model_state == HALTED))
        else fail_check("halted", xlen_t'(model_state == HALTED), xlen_t'(halted));
      assert (trap_active === (model_state == HANDLER))
        else fail_check("trap_active", xlen_t'(model_state == HANDLER), xlen_t'(trap_active));
    end
    if (rst)
      reset_model();
    else
      model_step();
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $fatal(1, "Timeout");
    end
  end

  // One cycle of inputs applied on the falling edge
  task automatic drive(input logic we, input csr_addr_t wa, input xlen_t wd, input logic re,
                       input csr_addr_t ra, input logic ex, input logic mr, input logic ret);
    @(negedge clk);
    csr_wr_en   = we;
    csr_wr_addr = wa;
    csr_wr_data = wd;
    csr_rd_en   = re;
    csr_rd_addr = ra;
    excp_req    = ex;
    mret_req    = mr;
    retire      = ret;
  endtask

  task automatic read_csr(input csr_addr_t addr);
    drive(1'b0, 12'h000, '0, 1'b1, addr, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic write_read(input csr_addr_t addr, input xlen_t data);
    drive(1'b1, addr, data, 1'b1, addr, 1'b0, 1'b0, 1'b0);
    read_csr(addr);
  endtask

  task automatic raise_exception(input exc_code_t code, input logic we, input csr_addr_t wa);
    drive(we, wa, rand64(), 1'b1, wa, 1'b1, 1'b0, 1'b0);
    excp_code = code;
    excp_pc   = rand64() | 64'h1;  // Odd PC so the bit 0 clear shows in mepc
    excp_tval = rand64();
  endtask

  task automatic read_all();
    foreach (writable_addrs[i])
      read_csr(writable_addrs[i]);
    foreach (read_only_addrs[i])
      read_csr(read_only_addrs[i]);
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst       = 1'b1;
    csr_wr_en = 1'b0;
    excp_req  = 1'b0;
    mret_req  = 1'b0;
    retire    = 1'b0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
  endtask

  initial begin
    xlen_t word;
    clk = 1'b0;
    rst = 1'b1;
    csr_rd_en = 1'b0;
    csr_rd_addr = '0;
    csr_wr_en = 1'b0;
    csr_wr_addr = '0;
    csr_wr_data = '0;
    excp_req = 1'b0;
    excp_code = '0;
    excp_pc = '0;
    excp_tval = '0;
    mret_req = 1'b0;
    retire = 1'b0;
    void'($urandom(32'h17af426b));
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_name = "reset_values";
    read_all();
    read_csr(12'h7c0);
    read_csr(12'hfff);
    drive(1'b0, 12'h000, '0, 1'b0, `CSR_MSTATUS, 1'b0, 1'b0, 1'b0);  // Read port off

    test_name = "software_access";
    repeat (SOFT_ROUNDS) begin
      foreach (writable_addrs[i])
        write_read(writable_addrs[i], rand64());
    end
    foreach (read_only_addrs[i])
      write_read(read_only_addrs[i], rand64());

    test_name = "trap_entry";
    write_read(`CSR_MTVEC, rand64() | 64'h3);  // Low bits set so the alignment shows
    write_read(`CSR_MSTATUS, `MSTATUS_RESET | 64'h8);
    raise_exception(4'd2, 1'b1, `CSR_MEPC);  // Same-edge mepc write loses
    read_csr(`CSR_MEPC);
    read_csr(`CSR_MCAUSE);
    read_csr(`CSR_MTVAL);
    read_csr(`CSR_MSTATUS);

    test_name = "trap_return";
    drive(1'b0, 12'h000, '0, 1'b1, `CSR_MSTATUS, 1'b0, 1'b1, 1'b0);
    read_csr(`CSR_MSTATUS);
    drive(1'b0, 12'h000, '0, 1'b1, `CSR_MEPC, 1'b0, 1'b1, 1'b0);
    read_csr(`CSR_MEPC);

    test_name = "counters";
    repeat (20) read_csr(`CSR_MCYCLE);
    write_read(`CSR_MCYCLE, rand64());
    repeat (5) read_csr(`CSR_MCYCLE);
    repeat (150) begin
      word = rand64();
      drive(1'b0, 12'h000, '0, 1'b1, `CSR_MINSTRET, 1'b0, 1'b0, word[0]);
    end
    write_read(`CSR_MINSTRET, rand64());
    repeat (30) begin
      word = rand64();
      drive(1'b0, 12'h000, '0, 1'b1, `CSR_MINSTRET, 1'b0, 1'b0, word[0]);
    end

    test_name = "double_trap";
    raise_exception(4'd5, 1'b0, `CSR_MEPC);
    read_csr(`CSR_MEPC);
    raise_exception(4'd7, 1'b0, `CSR_MCAUSE);
    read_csr(`CSR_MEPC);
    read_csr(`CSR_MTVAL);
    drive(1'b0, 12'h000, '0, 1'b1, `CSR_MSTATUS, 1'b0, 1'b1, 1'b0);
    raise_exception(4'd3, 1'b0, `CSR_MCAUSE);
    read_csr(`CSR_MSTATUS);
    apply_reset();
    test_name = "reset_after_halt";
    read_all();
    read_csr(`CSR_MSTATUS);

    $display("Test passed");
    $finish;
  end

endmodule

/* csr_unit_properties.sv */
// Concurrent assertions on the PC redirect pulse and the halt level, bound into the CSR unit
`timescale 1ns/10ps
`include "csr_defines.svh"

module csr_unit_properties (
  input logic clk,
  input logic rst,
  input logic redirect_valid,
  input logic halted
);

  // A redirect is a single-cycle pulse
  assert property (@(posedge clk) disable iff (rst) redirect_valid |=> !redirect_valid)
    else $error("redirect_valid stayed high for two cycles");

  // Double-trap halt is sticky until reset
  assert property (@(posedge clk) disable iff (rst) halted |=> halted)
    else $error("halted dropped without a reset");

  assert property (@(posedge clk) rst |=> !redirect_valid)
    else $error("redirect_valid was high in the cycle after reset");

endmodule

bind csr_unit csr_unit_properties i_props (
  .clk            (clk),
  .rst            (rst),
  .redirect_valid (redirect_valid),
  .halted         (halted)
);

/* csr_unit.sv */
// Machine CSR unit top with register file, trap FSM and the two counters
`timescale 1ns/10ps

module csr_unit
  import csr_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  // Read port
  input  logic      csr_rd_en,
  input  csr_addr_t csr_rd_addr,
  output xlen_t     csr_rd_data,
  output logic      csr_rd_illegal,
  // Write port
  input  logic      csr_wr_en,
  input  csr_addr_t csr_wr_addr,
  input  xlen_t     csr_wr_data,
  // Exception and return requests
  input  logic      excp_req,
  input  exc_code_t excp_code,
  input  xlen_t     excp_pc,
  input  xlen_t     excp_tval,
  input  logic      mret_req,
  input  logic      retire,
  // PC redirect and status
  output logic      redirect_valid,
  output xlen_t     redirect_pc,
  output logic      trap_active,
  output logic      halted
);

  logic  trap_enter;
  logic  trap_exit;
  logic  cycle_wr;
  logic  instret_wr;
  xlen_t mtvec;
  xlen_t mepc;
  xlen_t mcycle;
  xlen_t minstret;

  csr_regfile i_regfile (
    .clk            (clk),
    .rst            (rst),
    .csr_rd_en      (csr_rd_en),
    .csr_rd_addr    (csr_rd_addr),
    .csr_rd_data    (csr_rd_data),
    .csr_rd_illegal (csr_rd_illegal),
    .csr_wr_en      (csr_wr_en),
    .csr_wr_addr    (csr_wr_addr),
    .csr_wr_data    (csr_wr_data),
    .trap_enter     (trap_enter),
    .trap_exit      (trap_exit),
    .excp_code      (excp_code),
    .excp_pc        (excp_pc),
    .excp_tval      (excp_tval),
    .mcycle         (mcycle),
    .minstret       (minstret),
    .cycle_wr       (cycle_wr),
    .instret_wr     (instret_wr),
    .mtvec          (mtvec),
    .mepc           (mepc)
  );

  trap_ctrl i_trap_ctrl (
    .clk            (clk),
    .rst            (rst),
    .excp_req       (excp_req),
    .mret_req       (mret_req),
    .mtvec          (mtvec),
    .mepc           (mepc),
    .trap_enter     (trap_enter),
    .trap_exit      (trap_exit),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .trap_active    (trap_active),
    .halted         (halted)
  );

  // Free-running cycle count
  csr_counter i_mcycle (
    .clk     (clk),
    .rst     (rst),
    .inc     (1'b1),
    .wr      (cycle_wr),
    .wr_data (csr_wr_data),
    .count   (mcycle)
  );

  csr_counter i_minstret (
    .clk     (clk),
    .rst     (rst),
    .inc     (retire),  // One per retired instruction
    .wr      (instret_wr),
    .wr_data (csr_wr_data),
    .count   (minstret)
  );

endmodule

/* csr_regfile.sv */
// Machine CSR registers, address decode, read mux and trap-side CSR updates
`timescale 1ns/10ps
`include "csr_defines.svh"

module csr_regfile
  import csr_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      csr_rd_en,
  input  csr_addr_t csr_rd_addr,
  output xlen_t     csr_rd_data,
  output logic      csr_rd_illegal,
  input  logic      csr_wr_en,
  input  csr_addr_t csr_wr_addr,
  input  xlen_t     csr_wr_data,
  input  logic      trap_enter,
  input  logic      trap_exit,
  input  exc_code_t excp_code,
  input  xlen_t     excp_pc,
  input  xlen_t     excp_tval,
  input  xlen_t     mcycle,       // From the cycle counter
  input  xlen_t     minstret,     // From the retire counter
  output logic      cycle_wr,
  output logic      instret_wr,
  output xlen_t     mtvec,
  output xlen_t     mepc
);

  xlen_t mstatus;
  xlen_t mie;
  xlen_t mscratch;
  xlen_t mcause;
  xlen_t mtval;
  xlen_t mip;
  xlen_t mstatus_trap;

  // Write decode, read-only and unknown addresses fall through
  logic wr_mstatus, wr_mie, wr_mtvec, wr_mscratch;
  logic wr_mepc, wr_mcause, wr_mtval, wr_mip;

  assign wr_mstatus  = csr_wr_en && (csr_wr_addr == `CSR_MSTATUS);
  assign wr_mie      = csr_wr_en && (csr_wr_addr == `CSR_MIE);
  assign wr_mtvec    = csr_wr_en && (csr_wr_addr == `CSR_MTVEC);
  assign wr_mscratch = csr_wr_en && (csr_wr_addr == `CSR_MSCRATCH);
  assign wr_mepc     = csr_wr_en && (csr_wr_addr == `CSR_MEPC);
  assign wr_mcause   = csr_wr_en && (csr_wr_addr == `CSR_MCAUSE);
  assign wr_mtval    = csr_wr_en && (csr_wr_addr == `CSR_MTVAL);
  assign wr_mip      = csr_wr_en && (csr_wr_addr == `CSR_MIP);
  assign cycle_wr    = csr_wr_en && (csr_wr_addr == `CSR_MCYCLE);
  assign instret_wr  = csr_wr_en && (csr_wr_addr == `CSR_MINSTRET);

  // Interrupt enable stacking on trap entry and mret
  always_comb begin
    mstatus_trap = mstatus;
    if (trap_enter) begin
      mstatus_trap[`MSTATUS_MPIE_BIT] = mstatus[`MSTATUS_MIE_BIT];
      mstatus_trap[`MSTATUS_MIE_BIT]  = 1'b0;
    end else begin
      mstatus_trap[`MSTATUS_MIE_BIT]  = mstatus[`MSTATUS_MPIE_BIT];
      mstatus_trap[`MSTATUS_MPIE_BIT] = 1'b1;
    end
  end

  // Trap-side updates take priority over a software write at the same edge
  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= `MSTATUS_RESET;
      mepc    <= '0;
      mcause  <= '0;
      mtval   <= '0;
    end else begin
      if (trap_enter || trap_exit) begin
        mstatus <= mstatus_trap;
      end else if (wr_mstatus) begin
        mstatus <= csr_wr_data;
      end
      if (trap_enter) begin
        mepc   <= {excp_pc[`XLEN-1:1], 1'b0};  // Instruction alignment
        mcause <= `XLEN'(excp_code);
        mtval  <= excp_tval;
      end else begin
        if (wr_mepc) mepc <= csr_wr_data;
        if (wr_mcause) mcause <= csr_wr_data;
        if (wr_mtval) mtval <= csr_wr_data;
      end
    end
  end

  // Plain software registers
  always_ff @(posedge clk) begin
    if (rst) begin
      mie      <= '0;
      mtvec    <= '0;
      mscratch <= '0;
      mip      <= '0;
    end else begin
      if (wr_mie) mie <= csr_wr_data;
      if (wr_mtvec) mtvec <= csr_wr_data;
      if (wr_mscratch) mscratch <= csr_wr_data;
      if (wr_mip) mip <= csr_wr_data;  // Nothing sets mip from hardware
    end
  end

  // One-hot read selects
  logic rd_mstatus, rd_misa, rd_mie, rd_mtvec, rd_mscratch;
  logic rd_mepc, rd_mcause, rd_mtval, rd_mip, rd_mcycle, rd_minstret;
  logic rd_mvendorid, rd_marchid, rd_mimpid, rd_mhartid;
  logic rd_known;

  assign rd_mstatus   = (csr_rd_addr == `CSR_MSTATUS);
  assign rd_misa      = (csr_rd_addr == `CSR_MISA);
  assign rd_mie       = (csr_rd_addr == `CSR_MIE);
  assign rd_mtvec     = (csr_rd_addr == `CSR_MTVEC);
  assign rd_mscratch  = (csr_rd_addr == `CSR_MSCRATCH);
  assign rd_mepc      = (csr_rd_addr == `CSR_MEPC);
  assign rd_mcause    = (csr_rd_addr == `CSR_MCAUSE);
  assign rd_mtval     = (csr_rd_addr == `CSR_MTVAL);
  assign rd_mip       = (csr_rd_addr == `CSR_MIP);
  assign rd_mcycle    = (csr_rd_addr == `CSR_MCYCLE);
  assign rd_minstret  = (csr_rd_addr == `CSR_MINSTRET);
  assign rd_mvendorid = (csr_rd_addr == `CSR_MVENDORID);
  assign rd_marchid   = (csr_rd_addr == `CSR_MARCHID);
  assign rd_mimpid    = (csr_rd_addr == `CSR_MIMPID);
  assign rd_mhartid   = (csr_rd_addr == `CSR_MHARTID);

  assign rd_known = rd_mstatus | rd_misa | rd_mie | rd_mtvec | rd_mscratch
                  | rd_mepc | rd_mcause | rd_mtval | rd_mip | rd_mcycle
                  | rd_minstret | rd_mvendorid | rd_marchid | rd_mimpid | rd_mhartid;

  // ID registers read as zero, so only the live registers enter the mux
  assign csr_rd_data = {`XLEN{csr_rd_en}} & (
      ({`XLEN{rd_mstatus}}  & mstatus)
    | ({`XLEN{rd_misa}}     & `MISA_VALUE)
    | ({`XLEN{rd_mie}}      & mie)
    | ({`XLEN{rd_mtvec}}    & mtvec)
    | ({`XLEN{rd_mscratch}} & mscratch)
    | ({`XLEN{rd_mepc}}     & mepc)
    | ({`XLEN{rd_mcause}}   & mcause)
    | ({`XLEN{rd_mtval}}    & mtval)
    | ({`XLEN{rd_mip}}      & mip)
    | ({`XLEN{rd_mcycle}}   & mcycle)
    | ({`XLEN{rd_minstret}} & minstret)
  );

  assign csr_rd_illegal = csr_rd_en && !rd_known;

endmodule

/* trap_ctrl.sv */
// Trap FSM for exception entry, mret and double-trap halt, plus the PC redirect
`timescale 1ns/10ps
`include "csr_defines.svh"

module trap_ctrl
  import csr_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  excp_req,        // One-cycle exception pulse
  input  logic  mret_req,        // One-cycle mret pulse
  input  xlen_t mtvec,
  input  xlen_t mepc,
  output logic  trap_enter,      // Strobe to the regfile
  output logic  trap_exit,       // Strobe to the regfile
  output logic  redirect_valid,
  output xlen_t redirect_pc,
  output logic  trap_active,
  output logic  halted
);

  trap_state_t state;
  trap_state_t state_next;
  logic        double_trap;

  // Request acceptance
  // An exception always wins over an mret in the same cycle
  assign trap_enter  = excp_req && (state == RUN);
  assign double_trap = excp_req && (state == HANDLER);
  assign trap_exit   = mret_req && !excp_req && (state == HANDLER);

  always_comb begin
    state_next = state;
    case (state)
      RUN: begin
        if (trap_enter) begin
          state_next = HANDLER;
        end
      end
      HANDLER: begin
        if (double_trap) begin
          state_next = HALTED;
        end else if (trap_exit) begin
          state_next = RUN;
        end
      end
      HALTED: begin
        state_next = HALTED;  // Only rst leaves here
      end
      default: begin
        state_next = RUN;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= RUN;
    end else begin
      state <= state_next;
    end
  end

  // Redirect pulse follows the accepting edge by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      redirect_valid <= 1'b0;
    end else begin
      redirect_valid <= trap_enter || trap_exit;
    end
  end

  // Target sampled from the CSR values before the update edge
  always_ff @(posedge clk) begin
    if (trap_enter) begin
      redirect_pc <= {mtvec[`XLEN-1:2], 2'b00};  // Direct mode only
    end else if (trap_exit) begin
      redirect_pc <= mepc;
    end
  end

  assign trap_active = (state == HANDLER);
  assign halted      = (state == HALTED);

endmodule

/* csr_counter.sv */
// Loadable 64-bit performance counter with an increment enable
`timescale 1ns/10ps
`include "csr_defines.svh"

module csr_counter
  import csr_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  inc,      // Count this cycle
  input  logic  wr,       // Software load
  input  xlen_t wr_data,
  output xlen_t count
);

  // Load beats the increment, so a write reads back exactly next cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (wr) begin
      count <= wr_data;
    end else if (inc) begin
      count <= count + `XLEN'(1);
    end
  end

endmodule

/* csr_pkg.sv */
// Shared CSR word, address, exception code and trap state types
`include "csr_defines.svh"

package csr_pkg;

  // One machine word
  typedef logic [`XLEN-1:0] xlen_t;

  // CSR address as encoded in the instruction
  typedef logic [11:0] csr_addr_t;

  // Synchronous exception code, zero-extended into mcause
  typedef logic [3:0] exc_code_t;

  // Trap sequencing
  typedef enum logic [1:0] {
    RUN,      // Normal execution
    HANDLER,  // Inside the trap handler, waiting for mret
    HALTED    // Double trap, stuck until reset
  } trap_state_t;

endpackage

/* csr_defines.svh */
// Word width, machine CSR addresses, reset and constant values, mstatus bit positions
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

`define XLEN 64

// Machine trap setup and handling
`define CSR_MSTATUS   12'h300
`define CSR_MISA      12'h301
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343
`define CSR_MIP       12'h344

// Machine counters
`define CSR_MCYCLE    12'hB00
`define CSR_MINSTRET  12'hB02

// Machine information, read only
`define CSR_MVENDORID 12'hF11
`define CSR_MARCHID   12'hF12
`define CSR_MIMPID    12'hF13
`define CSR_MHARTID   12'hF14

`define MSTATUS_RESET 64'h0000_0000_0000_1800  // MPP = M, MIE = MPIE = 0
`define MISA_VALUE    64'h8000_0000_0000_0100  // MXL = 2 (RV64), base I only

// mstatus trap fields
`define MSTATUS_MIE_BIT  3
`define MSTATUS_MPIE_BIT 7

`endif
